/* hdl/join_consts.svh */
//////////////////////////////
// Width constants for the narrow/wide join
// Address, data and ID widths, lane count
//////////////////////////////

`ifndef JOIN_CONSTS_SVH
`define JOIN_CONSTS_SVH

// Byte address
`define JOIN_ADDR_W 16

// Data widths of the two source ports
`define JOIN_NARROW_W 32
`define JOIN_WIDE_W 128
// Narrow words per wide word
`define JOIN_LANES 4

// Source ID and ID with the source bit on top
`define JOIN_ID_IN_W 3
`define JOIN_ID_OUT_W 4

`endif

/* hdl/join_bus_pkg.sv */
//////////////////////////////
// Bus payload types
// Address, data, strobe and ID
//////////////////////////////

`include "join_consts.svh"

package join_bus_pkg;

  // Byte address, shared by both sources and the memory port
  typedef logic [`JOIN_ADDR_W-1:0] addr_t;

  // Narrow source side
  typedef logic [`JOIN_NARROW_W-1:0] narrow_data_t;
  typedef logic [`JOIN_NARROW_W/8-1:0] narrow_strb_t;

  // Wide source side and memory side
  typedef logic [`JOIN_WIDE_W-1:0] wide_data_t;
  typedef logic [`JOIN_WIDE_W/8-1:0] wide_strb_t;

  // IDs before and after widening
  typedef logic [`JOIN_ID_IN_W-1:0] id_in_t;
  typedef logic [`JOIN_ID_OUT_W-1:0] id_out_t;

endpackage

/* hdl/join_src_pkg.sv */
//////////////////////////////
// Source-side types
// Source select and lane index
//////////////////////////////

`include "join_consts.svh"

package join_src_pkg;

  // Also the top bit of the outgoing ID
  typedef enum logic {SRC_NARROW = 1'b0, SRC_WIDE = 1'b1} src_e;

  typedef logic [$clog2(`JOIN_LANES)-1:0] lane_t;

endpackage

/* hdl/narrow_lane_steer.sv */
//////////////////////////////
// Narrow to wide lane steering
// Write data/strobe placement, read lane pick
//////////////////////////////

`timescale 1ns/1ps

`include "join_consts.svh"

module narrow_lane_steer (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      capture_i,
  input  join_bus_pkg::addr_t       addr_i,
  input  join_bus_pkg::narrow_data_t wdata_i,
  input  join_bus_pkg::narrow_strb_t strb_i,
  input  join_bus_pkg::wide_data_t  rdata_wide_i,
  output join_bus_pkg::wide_data_t  wdata_wide_o,
  output join_bus_pkg::wide_strb_t  strb_wide_o,
  output join_bus_pkg::narrow_data_t rdata_o
);

  // Byte offset bits inside one narrow word
  localparam int unsigned OffsetBits = $clog2(`JOIN_NARROW_W / 8);
  localparam int unsigned StrbW = `JOIN_NARROW_W / 8;

  join_src_pkg::lane_t lane;
  join_src_pkg::lane_t lane_q;

  // Lane comes from the address bits just above the byte offset
  assign lane = addr_i[OffsetBits +: $bits(join_src_pkg::lane_t)];

  ////////////////////////////////
  // Write path
  ////////////////////////////////

  always_comb begin
    wdata_wide_o = '0;
    strb_wide_o  = '0;
    wdata_wide_o[lane*`JOIN_NARROW_W +: `JOIN_NARROW_W] = wdata_i;
    // Other lanes keep a zero strobe so memory leaves them alone
    strb_wide_o[lane*StrbW +: StrbW] = strb_i;
  end

  ////////////////////////////////
  // Read path
  ////////////////////////////////

  // Lane is kept from acceptance until the response is handed back
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lane_q <= '0;
    end else if (capture_i) begin
      lane_q <= lane;
    end
  end

  assign rdata_o = rdata_wide_i[lane_q*`JOIN_NARROW_W +: `JOIN_NARROW_W];

endmodule

/* hdl/ingress_slot.sv */
//////////////////////////////
// Ingress slot
// Four-phase slave holding one request
//////////////////////////////

`timescale 1ns/1ps

module ingress_slot (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  join_bus_pkg::addr_t      addr_i,
  input  join_bus_pkg::wide_data_t wdata_i,
  input  join_bus_pkg::wide_strb_t strb_i,
  input  join_bus_pkg::id_in_t     id_i,
  input  logic                     done_i,
  input  join_bus_pkg::wide_data_t rdata_i,
  output logic                     ack_o,
  output logic                     capture_o,
  output logic                     pend_o,
  output logic                     we_o,
  output join_bus_pkg::addr_t      addr_o,
  output join_bus_pkg::wide_data_t wdata_o,
  output join_bus_pkg::wide_strb_t strb_o,
  output join_bus_pkg::id_in_t     id_o,
  output join_bus_pkg::wide_data_t rdata_o
);

  typedef enum logic [1:0] {SLOT_IDLE, SLOT_PEND, SLOT_ACK} slot_state_e;

  slot_state_e state_q;
  slot_state_e state_d;

  ////////////////////////////////
  // Handshake FSM
  ////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      SLOT_IDLE: begin
        if (req_i) begin
          state_d = SLOT_PEND;
        end
      end
      // Waiting for the arbiter to finish the memory access
      SLOT_PEND: begin
        if (done_i) begin
          state_d = SLOT_ACK;
        end
      end
      SLOT_ACK: begin
        if (!req_i) begin
          state_d = SLOT_IDLE;
        end
      end
      default: state_d = SLOT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= SLOT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign capture_o = (state_q == SLOT_IDLE) && req_i;
  assign pend_o    = (state_q == SLOT_PEND);
  assign ack_o     = (state_q == SLOT_ACK);

  ////////////////////////////////
  // Request and response storage
  ////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (capture_o) begin
      we_o    <= we_i;
      addr_o  <= addr_i;
      wdata_o <= wdata_i;
      strb_o  <= strb_i;
      id_o    <= id_i;
    end
    // Held until the source has seen ack
    if (pend_o && done_i) begin
      rdata_o <= rdata_i;
    end
  end

  // The source keeps req up until it has seen ack
  ack_needs_req_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(ack_o) |-> req_i);

endmodule

/* hdl/join_arbiter.sv */
//////////////////////////////
// Round-robin arbiter
// Four-phase master toward memory, ID widening
//////////////////////////////

`timescale 1ns/1ps

module join_arbiter (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [1:0]               pend_i,
  input  logic [1:0]               we_i,
  input  join_bus_pkg::addr_t      addr_i [2],
  input  join_bus_pkg::wide_data_t wdata_i [2],
  input  join_bus_pkg::wide_strb_t strb_i [2],
  input  join_bus_pkg::id_in_t     id_i [2],
  input  logic                     mem_ack_i,
  input  join_bus_pkg::wide_data_t mem_rdata_i,
  output logic [1:0]               done_o,
  output join_bus_pkg::wide_data_t rdata_o,
  output logic                     mem_req_o,
  output logic                     mem_we_o,
  output join_bus_pkg::addr_t      mem_addr_o,
  output join_bus_pkg::wide_data_t mem_wdata_o,
  output join_bus_pkg::wide_strb_t mem_strb_o,
  output join_bus_pkg::id_out_t    mem_id_o
);

  typedef enum logic [1:0] {ARB_IDLE, ARB_REQ, ARB_RELEASE} arb_state_e;

  arb_state_e         state_q;
  // Source served last, or being served now
  join_src_pkg::src_e grant_q;
  join_src_pkg::src_e grant_d;
  logic               start;

  ////////////////////////////////
  // Grant selection
  ////////////////////////////////

  // Wide wins alone, or in a tie when narrow went last
  always_comb begin
    if (pend_i[join_src_pkg::SRC_WIDE] &&
        (!pend_i[join_src_pkg::SRC_NARROW] || grant_q == join_src_pkg::SRC_NARROW)) begin
      grant_d = join_src_pkg::SRC_WIDE;
    end else begin
      grant_d = join_src_pkg::SRC_NARROW;
    end
  end

  assign start = (state_q == ARB_IDLE) && (|pend_i);

  ////////////////////////////////
  // Memory handshake
  ////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q   <= ARB_IDLE;
      grant_q   <= join_src_pkg::SRC_WIDE;
      mem_req_o <= 1'b0;
      done_o    <= '0;
    end else begin
      done_o <= '0;
      case (state_q)
        ARB_IDLE: begin
          if (start) begin
            grant_q   <= grant_d;
            mem_req_o <= 1'b1;
            state_q   <= ARB_REQ;
          end
        end
        ARB_REQ: begin
          if (mem_ack_i) begin
            mem_req_o       <= 1'b0;
            done_o[grant_q] <= 1'b1;
            state_q         <= ARB_RELEASE;
          end
        end
        // Memory must drop ack before the next grant
        ARB_RELEASE: begin
          if (!mem_ack_i) begin
            state_q <= ARB_IDLE;
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  // Payload is stable for the whole request
  always_ff @(posedge clk_i) begin
    if (start) begin
      mem_we_o    <= we_i[grant_d];
      mem_addr_o  <= addr_i[grant_d];
      mem_wdata_o <= wdata_i[grant_d];
      mem_strb_o  <= strb_i[grant_d];
      mem_id_o    <= {grant_d, id_i[grant_d]};
    end
    if (state_q == ARB_REQ && mem_ack_i) begin
      rdata_o <= mem_rdata_i;
    end
  end

  // At most one done, and only toward a slot that is still waiting
  done_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(done_o) && ((done_o & ~pend_i) == 2'b00));

  mem_req_after_ack_low_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(mem_req_o) |-> !mem_ack_i);

endmodule

/* hdl/narrow_wide_join.sv */
//////////////////////////////
// Narrow/wide join top level
// Lane steering, two ingress slots, arbiter
//////////////////////////////

`timescale 1ns/1ps

module narrow_wide_join (
  input  logic                       clk_i,
  input  logic                       reset_i,
  // Narrow source
  input  logic                       n_req_i,
  input  logic                       n_we_i,
  input  join_bus_pkg::addr_t        n_addr_i,
  input  join_bus_pkg::narrow_data_t n_wdata_i,
  input  join_bus_pkg::narrow_strb_t n_strb_i,
  input  join_bus_pkg::id_in_t       n_id_i,
  output logic                       n_ack_o,
  output join_bus_pkg::narrow_data_t n_rdata_o,
  // Wide source
  input  logic                       w_req_i,
  input  logic                       w_we_i,
  input  join_bus_pkg::addr_t        w_addr_i,
  input  join_bus_pkg::wide_data_t   w_wdata_i,
  input  join_bus_pkg::wide_strb_t   w_strb_i,
  input  join_bus_pkg::id_in_t       w_id_i,
  output logic                       w_ack_o,
  output join_bus_pkg::wide_data_t   w_rdata_o,
  // Memory
  output logic                       mem_req_o,
  output logic                       mem_we_o,
  output join_bus_pkg::addr_t        mem_addr_o,
  output join_bus_pkg::wide_data_t   mem_wdata_o,
  output join_bus_pkg::wide_strb_t   mem_strb_o,
  output join_bus_pkg::id_out_t      mem_id_o,
  input  logic                       mem_ack_i,
  input  join_bus_pkg::wide_data_t   mem_rdata_i
);

  // Slot inputs, index 0 narrow and index 1 wide
  logic [1:0]               in_req;
  logic [1:0]               in_we;
  join_bus_pkg::addr_t      in_addr [2];
  join_bus_pkg::wide_data_t in_wdata [2];
  join_bus_pkg::wide_strb_t in_strb [2];
  join_bus_pkg::id_in_t     in_id [2];

  // Slot outputs
  logic [1:0]               slot_ack;
  logic [1:0]               slot_capture;
  logic [1:0]               slot_pend;
  logic [1:0]               slot_we;
  join_bus_pkg::addr_t      slot_addr [2];
  join_bus_pkg::wide_data_t slot_wdata [2];
  join_bus_pkg::wide_strb_t slot_strb [2];
  join_bus_pkg::id_in_t     slot_id [2];
  join_bus_pkg::wide_data_t slot_rdata [2];

  logic [1:0]               done;
  join_bus_pkg::wide_data_t arb_rdata;

  assign in_req     = {w_req_i, n_req_i};
  assign in_we      = {w_we_i, n_we_i};
  assign in_addr[0] = n_addr_i;
  assign in_addr[1] = w_addr_i;
  assign in_id[0]   = n_id_i;
  assign in_id[1]   = w_id_i;
  // Wide source needs no conversion
  assign in_wdata[1] = w_wdata_i;
  assign in_strb[1]  = w_strb_i;

  narrow_lane_steer narrow_lane_steer_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .capture_i    (slot_capture[0]),
    .addr_i       (n_addr_i),
    .wdata_i      (n_wdata_i),
    .strb_i       (n_strb_i),
    .rdata_wide_i (slot_rdata[0]),
    .wdata_wide_o (in_wdata[0]),
    .strb_wide_o  (in_strb[0]),
    .rdata_o      (n_rdata_o)
  );

  for (genvar g = 0; g < 2; g++) begin : gen_slot
    ingress_slot ingress_slot_i (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .req_i     (in_req[g]),
      .we_i      (in_we[g]),
      .addr_i    (in_addr[g]),
      .wdata_i   (in_wdata[g]),
      .strb_i    (in_strb[g]),
      .id_i      (in_id[g]),
      .done_i    (done[g]),
      .rdata_i   (arb_rdata),
      .ack_o     (slot_ack[g]),
      .capture_o (slot_capture[g]),
      .pend_o    (slot_pend[g]),
      .we_o      (slot_we[g]),
      .addr_o    (slot_addr[g]),
      .wdata_o   (slot_wdata[g]),
      .strb_o    (slot_strb[g]),
      .id_o      (slot_id[g]),
      .rdata_o   (slot_rdata[g])
    );
  end

  join_arbiter join_arbiter_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .pend_i      (slot_pend),
    .we_i        (slot_we),
    .addr_i      (slot_addr),
    .wdata_i     (slot_wdata),
    .strb_i      (slot_strb),
    .id_i        (slot_id),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i),
    .done_o      (done),
    .rdata_o     (arb_rdata),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_strb_o  (mem_strb_o),
    .mem_id_o    (mem_id_o)
  );

  assign n_ack_o   = slot_ack[0];
  assign w_ack_o   = slot_ack[1];
  assign w_rdata_o = slot_rdata[1];

endmodule

/* testbench/tb_clock_gen.sv */
//////////////////////////////
// Testbench clock and reset
//////////////////////////////

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int ClkPeriod   = 20,
  parameter int ResetCycles = 2
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(ClkPeriod / 2) clk_o = ~clk_o;
  end

  // Reset leaves 2 ns after an edge, like the other inputs
  initial begin
    reset_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    reset_o = 1'b0;
  end

endmodule

/* testbench/tb_narrow_wide_join.sv */
//////////////////////////////
// Testbench for the narrow/wide join
// Random sources, memory model, checks
//////////////////////////////

`timescale 1ns/1ps

`include "join_consts.svh"

module tb_narrow_wide_join;

  localparam int ClkPeriod = 20;
  localparam int NumTxn = 150;
  // Two sources, each given 40 cycles per transaction
  localparam int TimeoutCycles = 2 * NumTxn * 40;
  localparam int NarrowStrbW = `JOIN_NARROW_W / 8;

  logic clk;
  logic reset;

  logic                       n_req;
  logic                       n_we;
  join_bus_pkg::addr_t        n_addr;
  join_bus_pkg::narrow_data_t n_wdata;
  join_bus_pkg::narrow_strb_t n_strb;
  join_bus_pkg::id_in_t       n_id;
  logic                       n_ack;
  join_bus_pkg::narrow_data_t n_rdata;
  logic                       w_req;
  logic                       w_we;
  join_bus_pkg::addr_t        w_addr;
  join_bus_pkg::wide_data_t   w_wdata;
  join_bus_pkg::wide_strb_t   w_strb;
  join_bus_pkg::id_in_t       w_id;
  logic                       w_ack;
  join_bus_pkg::wide_data_t   w_rdata;
  logic                       mem_req;
  logic                       mem_we;
  join_bus_pkg::addr_t        mem_addr;
  join_bus_pkg::wide_data_t   mem_wdata;
  join_bus_pkg::wide_strb_t   mem_strb;
  join_bus_pkg::id_out_t      mem_id;
  logic                       mem_ack;
  join_bus_pkg::wide_data_t   mem_rdata;

  logic [15:0] lfsr = 16'd47;
  int errors = 0;
  int checks = 0;

  // Reference model, index 0 narrow and index 1 wide
  join_bus_pkg::wide_data_t model_mem [logic [11:0]];
  logic                     exp_we [2];
  join_bus_pkg::addr_t      exp_addr [2];
  join_bus_pkg::wide_data_t exp_wdata [2];
  join_bus_pkg::wide_strb_t exp_strb [2];
  join_bus_pkg::id_out_t    exp_id [2];
  logic [1:0]               open_txn;
  int                       served [2];
  join_bus_pkg::wide_data_t served_word [2];

  // Previous samples for the handshake monitor
  logic n_req_prev = 1'b0;
  logic n_ack_prev = 1'b0;
  logic w_req_prev = 1'b0;
  logic w_ack_prev = 1'b0;
  logic mem_req_prev = 1'b0;
  logic mem_ack_prev = 1'b0;

  tb_clock_gen #(.ClkPeriod(ClkPeriod), .ResetCycles(2)) tb_clock_gen_i (
    .clk_o   (clk),
    .reset_o (reset)
  );

  narrow_wide_join narrow_wide_join_i (
    .clk_i       (clk),
    .reset_i     (reset),
    .n_req_i     (n_req),
    .n_we_i      (n_we),
    .n_addr_i    (n_addr),
    .n_wdata_i   (n_wdata),
    .n_strb_i    (n_strb),
    .n_id_i      (n_id),
    .n_ack_o     (n_ack),
    .n_rdata_o   (n_rdata),
    .w_req_i     (w_req),
    .w_we_i      (w_we),
    .w_addr_i    (w_addr),
    .w_wdata_i   (w_wdata),
    .w_strb_i    (w_strb),
    .w_id_i      (w_id),
    .w_ack_o     (w_ack),
    .w_rdata_o   (w_rdata),
    .mem_req_o   (mem_req),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_strb_o  (mem_strb),
    .mem_id_o    (mem_id),
    .mem_ack_i   (mem_ack),
    .mem_rdata_i (mem_rdata)
  );

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Taps 16, 14, 13, 11 give a maximal length sequence
  function automatic logic [15:0] next_lfsr(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic take_bits(input int count, output logic [127:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr = next_lfsr(lfsr);
      value = {value[126:0], lfsr[0]};
    end
  endtask

  function automatic join_bus_pkg::wide_data_t byte_mask(input join_bus_pkg::wide_strb_t strb);
    join_bus_pkg::wide_data_t mask;
    mask = '0;
    for (int b = 0; b < `JOIN_WIDE_W / 8; b++) begin
      mask[b*8 +: 8] = {8{strb[b]}};
    end
    return mask;
  endfunction

  function automatic join_bus_pkg::wide_data_t read_word(input join_bus_pkg::addr_t addr);
    if (model_mem.exists(addr[15:4])) begin
      return model_mem[addr[15:4]];
    end
    // Unwritten words hold a pattern made from their address
    return {8{4'hc, addr[15:4]}};
  endfunction

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED %s expected %h got %h", name, expected, actual);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  //////////////////////////////
  // Sources
  //////////////////////////////

  task automatic run_narrow(input int count);
    logic [127:0] r;
    join_src_pkg::lane_t lane;
    for (int i = 0; i < count; i++) begin
      take_bits(2, r);
      repeat (int'(r[1:0])) @(posedge clk);
      @(posedge clk);
      #2;
      take_bits(1, r);
      n_we = r[0];
      take_bits(8, r);
      n_addr = {8'h00, r[7:0]};
      take_bits(32, r);
      n_wdata = r[31:0];
      take_bits(4, r);
      n_strb = r[3:0];
      take_bits(3, r);
      n_id = r[2:0];
      lane = n_addr[3:2];
      // What the memory should see after lane steering
      exp_we[0] = n_we;
      exp_addr[0] = n_addr;
      exp_wdata[0] = join_bus_pkg::wide_data_t'(n_wdata) << (lane * `JOIN_NARROW_W);
      exp_strb[0] = join_bus_pkg::wide_strb_t'(n_strb) << (lane * NarrowStrbW);
      exp_id[0] = {join_src_pkg::SRC_NARROW, n_id};
      served[0] = 0;
      open_txn[0] = 1'b1;
      n_req = 1'b1;
      while (n_ack !== 1'b1) @(negedge clk);
      if (served[0] != 1) begin
        report_error($sformatf("Narrow transaction reached memory %0d times", served[0]));
      end
      if (!exp_we[0]) begin
        check_value("n_rdata_o", 128'(served_word[0][lane*`JOIN_NARROW_W +: `JOIN_NARROW_W]),
                    128'(n_rdata));
      end
      open_txn[0] = 1'b0;
      @(posedge clk);
      #2;
      n_req = 1'b0;
      while (n_ack !== 1'b0) @(negedge clk);
    end
  endtask

  task automatic run_wide(input int count);
    logic [127:0] r;
    for (int i = 0; i < count; i++) begin
      take_bits(2, r);
      repeat (int'(r[1:0])) @(posedge clk);
      @(posedge clk);
      #2;
      take_bits(1, r);
      w_we = r[0];
      take_bits(8, r);
      w_addr = {8'h00, r[7:0]};
      take_bits(128, r);
      w_wdata = r;
      take_bits(16, r);
      w_strb = r[15:0];
      take_bits(3, r);
      w_id = r[2:0];
      exp_we[1] = w_we;
      exp_addr[1] = w_addr;
      exp_wdata[1] = w_wdata;
      exp_strb[1] = w_strb;
      exp_id[1] = {join_src_pkg::SRC_WIDE, w_id};
      served[1] = 0;
      open_txn[1] = 1'b1;
      w_req = 1'b1;
      while (w_ack !== 1'b1) @(negedge clk);
      if (served[1] != 1) begin
        report_error($sformatf("Wide transaction reached memory %0d times", served[1]));
      end
      if (!exp_we[1]) begin
        check_value("w_rdata_o", served_word[1], w_rdata);
      end
      open_txn[1] = 1'b0;
      @(posedge clk);
      #2;
      w_req = 1'b0;
      while (w_ack !== 1'b0) @(negedge clk);
    end
  endtask

  //////////////////////////////
  // Memory model
  //////////////////////////////

  always begin : memory_model
    logic [127:0] r;
    logic src;
    join_bus_pkg::wide_data_t word;
    join_bus_pkg::wide_data_t mask;
    while (mem_req !== 1'b1 || reset !== 1'b0) @(negedge clk);
    src = mem_id[3];
    if (!open_txn[src] || served[src] != 0) begin
      report_error($sformatf("Memory request for source %0d with no open transaction", src));
    end
    check_value("mem_id_o", 128'(exp_id[src]), 128'(mem_id));
    check_value("mem_we_o", 128'(exp_we[src]), 128'(mem_we));
    check_value("mem_addr_o", 128'(exp_addr[src]), 128'(mem_addr));
    if (exp_we[src]) begin
      mask = byte_mask(exp_strb[src]);
      check_value("mem_strb_o", 128'(exp_strb[src]), 128'(mem_strb));
      check_value("mem_wdata_o", exp_wdata[src] & mask, mem_wdata & mask);
    end
    take_bits(2, r);
    repeat (int'(r[1:0])) @(posedge clk);
    @(posedge clk);
    #2;
    word = read_word(mem_addr);
    served_word[src] = word;
    served[src] = served[src] + 1;
    if (mem_we === 1'b1) begin
      mask = byte_mask(mem_strb);
      word = (word & ~mask) | (mem_wdata & mask);
      model_mem[mem_addr[15:4]] = word;
    end
    mem_rdata = word;
    mem_ack = 1'b1;
    while (mem_req !== 1'b0) @(negedge clk);
    @(posedge clk);
    #2;
    mem_ack = 1'b0;
  end

  //////////////////////////////
  // Handshake monitor
  //////////////////////////////

  task automatic check_handshake(input string port, input logic req, input logic ack,
                                 input logic req_prev, input logic ack_prev);
    if (ack && !ack_prev && !req) begin
      report_error($sformatf("%s rose without a request", port));
    end
    if (!ack && ack_prev && req_prev) begin
      report_error($sformatf("%s fell while the request was still high", port));
    end
  endtask

  always @(negedge clk) begin
    if (reset === 1'b0) begin
      check_handshake("n_ack_o", n_req, n_ack, n_req_prev, n_ack_prev);
      check_handshake("w_ack_o", w_req, w_ack, w_req_prev, w_ack_prev);
      if (mem_req && !mem_req_prev && mem_ack) begin
        report_error("Memory request raised while the previous ack was still high");
      end
      if (!mem_req && mem_req_prev && !mem_ack_prev) begin
        report_error("Memory request withdrawn before ack");
      end
    end
    n_req_prev = n_req;
    n_ack_prev = n_ack;
    w_req_prev = w_req;
    w_ack_prev = w_ack;
    mem_req_prev = mem_req;
    mem_ack_prev = mem_ack;
  end

  //////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////

  initial begin
    n_req = 1'b0;
    n_we = 1'b0;
    n_addr = '0;
    n_wdata = '0;
    n_strb = '0;
    n_id = '0;
    w_req = 1'b0;
    w_we = 1'b0;
    w_addr = '0;
    w_wdata = '0;
    w_strb = '0;
    w_id = '0;
    mem_ack = 1'b0;
    mem_rdata = '0;
    open_txn = '0;
    served[0] = 0;
    served[1] = 0;
    while (reset !== 1'b0) @(negedge clk);
    check_value("n_ack_o", '0, 128'(n_ack));
    check_value("w_ack_o", '0, 128'(w_ack));
    check_value("mem_req_o", '0, 128'(mem_req));
    fork
      run_narrow(NumTxn);
      run_wide(NumTxn);
    join
    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("Timeout after %0d cycles with transactions still running", TimeoutCycles);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Verification failed");
    $finish;
  end

endmodule

/* narrow_wide_join.f */
+incdir+hdl
hdl/join_bus_pkg.sv
hdl/join_src_pkg.sv
hdl/narrow_lane_steer.sv
hdl/ingress_slot.sv
hdl/join_arbiter.sv
hdl/narrow_wide_join.sv
testbench/tb_clock_gen.sv
testbench/tb_narrow_wide_join.sv

/* Makefile */
# Verilator build for the narrow/wide join

VERILATOR  = verilator
TOP        = tb_narrow_wide_join
FILELIST   = narrow_wide_join.f
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert
OBJ_DIR    = obj_dir
PASS_MSG   = Verification passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run fails unless the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
